// File: verilog/conv_pkg.sv
package conv_pkg;

    // Widths with a meaning in the converter

    // Single-precision pattern, sign / exponent / fraction
    typedef logic [31:0] fp32_t;

    // Leading-zero count of a 32-bit word, 0 to 32
    typedef logic [5:0] lzc_t;

    // IEEE-754 single-precision exponent bias
    localparam logic [7:0] FP32_BIAS = 8'd127;

    // Converter depth in cycles, accept to output handshake
    localparam int CONV_LATENCY = 5;

    // Occupancy of a one-slot elastic half buffer
    typedef enum logic {
        BUF_EMPTY = 1'b0,
        BUF_FULL  = 1'b1
    } buf_state_t;

endpackage

// File: verilog/delay_buffer.sv
`timescale 1ns/100ps

module delay_buffer #(
    parameter int DELAY_SIZE = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic ins_valid,
    input  logic outs_ready,
    output logic outs_valid
);

    // Valid bits in flight, index 0 is the newest
    logic [DELAY_SIZE-1:0] valid_q;

    // Enabled cycles since reset, saturates at DELAY_SIZE
    logic [$clog2(DELAY_SIZE+1)-1:0] warm_cnt;

    // Whole chain moves together, only when downstream takes a step
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (outs_ready) begin
            valid_q[0] <= ins_valid;
            for (int i = 1; i < DELAY_SIZE; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    assign outs_valid = valid_q[DELAY_SIZE-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            warm_cnt <= '0;
        end else if (outs_ready && (warm_cnt < DELAY_SIZE)) begin
            warm_cnt <= warm_cnt + 1'b1;
        end
    end

    // Nothing can reach the end of the chain before it has been filled
    a_quiet_after_reset : assert property (@(posedge clk) disable iff (rst)
        (warm_cnt < DELAY_SIZE) |-> !outs_valid);

endmodule

// File: verilog/oehb.sv
`timescale 1ns/100ps

module oehb import conv_pkg::*; #(
    parameter int DATA_TYPE = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [DATA_TYPE-1:0] ins,
    input  logic                 ins_valid,
    input  logic                 outs_ready,
    output logic [DATA_TYPE-1:0] outs,
    output logic                 outs_valid,
    output logic                 ins_ready
);

    buf_state_t           state;
    logic [DATA_TYPE-1:0] data_q;

    // ------------------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------------------

    // Slot free, or the held token leaves this cycle
    assign ins_ready  = (state == BUF_EMPTY) || outs_ready;
    assign outs_valid = (state == BUF_FULL);
    assign outs       = data_q;

    // Occupancy follows the incoming valid whenever the slot can turn over
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= BUF_EMPTY;
        end else if (ins_ready) begin
            state <= ins_valid ? BUF_FULL : BUF_EMPTY;
        end
    end

    // ------------------------------------------------------------------------
    // Payload
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (ins_valid && ins_ready) begin
            data_q <= ins;
        end
    end

    // Stalled output keeps both its valid and its value
    a_hold_on_stall : assert property (@(posedge clk) disable iff (rst)
        (outs_valid && !outs_ready) |=> (outs_valid && $stable(outs)));

endmodule

// File: verilog/tehb.sv
`timescale 1ns/100ps

module tehb import conv_pkg::*; #(
    parameter int DATA_TYPE = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [DATA_TYPE-1:0] ins,
    input  logic                 ins_valid,
    input  logic                 outs_ready,
    output logic [DATA_TYPE-1:0] outs,
    output logic                 outs_valid,
    output logic                 ins_ready
);

    buf_state_t           state;
    logic [DATA_TYPE-1:0] data_q;

    // Ready upstream comes from the state register only
    assign ins_ready = (state == BUF_EMPTY);

    // Stored token goes out ahead of the input
    assign outs_valid = ins_valid || (state == BUF_FULL);
    assign outs       = (state == BUF_FULL) ? data_q : ins;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= BUF_EMPTY;
        end else begin
            case (state)
                BUF_EMPTY: if (ins_valid && !outs_ready) state <= BUF_FULL;
                BUF_FULL:  if (outs_ready) state <= BUF_EMPTY;
                default:   state <= BUF_EMPTY;
            endcase
        end
    end

    // Capture only the token that downstream refused
    always_ff @(posedge clk) begin
        if ((state == BUF_EMPTY) && ins_valid && !outs_ready) begin
            data_q <= ins;
        end
    end

    // Producer keeps the token that the full slot refuses
    a_no_accept_full : assert property (@(posedge clk) disable iff (rst)
        ((state == BUF_FULL) && ins_valid) |=> (ins_valid && $stable(ins)));

endmodule

// File: verilog/uitofp.sv
`timescale 1ns/100ps

module uitofp import conv_pkg::*; #(
    parameter int DATA_TYPE = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [DATA_TYPE-1:0] ins,
    input  logic                 ins_valid,
    input  logic                 outs_ready,
    output fp32_t                outs,
    output logic                 outs_valid,
    output logic                 ins_ready
);

    // ------------------------------------------------------------------------
    // Conversion, combinational into q0
    // ------------------------------------------------------------------------

    logic [31:0] ext_val;
    lzc_t        lzc;
    logic [31:0] shifted;
    logic [7:0]  exp_val;
    fp32_t       converted;

    // Zero extension of narrow inputs
    always_comb begin
        ext_val                 = '0;
        ext_val[DATA_TYPE-1:0]  = ins;
    end

    // Upward scan, last hit is the leading one
    always_comb begin
        lzc = lzc_t'(32);
        for (int i = 0; i < 32; i++) begin
            if (ext_val[i]) begin
                lzc = lzc_t'(31 - i);
            end
        end
    end

    // Leading one lands on bit 31 and is implicit
    assign shifted = ext_val << lzc;
    assign exp_val = FP32_BIAS + {2'b00, 6'd31 - lzc};

    // Bits below the kept 23 are dropped, i.e. truncation
    assign converted = (ext_val == '0) ? '0 : {1'b0, exp_val, shifted[30:8]};

    // ------------------------------------------------------------------------
    // Data stages q0..q3, fifth stage is the oehb register
    // ------------------------------------------------------------------------

    fp32_t q0, q1, q2, q3;
    logic  oehb_ready;
    logic  dly_valid;

    // Single enable for the whole pipe
    always_ff @(posedge clk) begin
        if (oehb_ready) begin
            q0 <= converted;
            q1 <= q0;
            q2 <= q1;
            q3 <= q2;
        end
    end

    // Valid runs beside q0..q3
    delay_buffer #(
        .DELAY_SIZE(CONV_LATENCY - 1)
    ) delay_buffer_inst (
        .clk       (clk),
        .rst       (rst),
        .ins_valid (ins_valid),
        .outs_ready(oehb_ready),
        .outs_valid(dly_valid)
    );

    // Output slot, its ready stalls everything upstream
    oehb #(
        .DATA_TYPE($bits(fp32_t))
    ) oehb_inst (
        .clk       (clk),
        .rst       (rst),
        .ins       (q3),
        .ins_valid (dly_valid),
        .outs_ready(outs_ready),
        .outs      (outs),
        .outs_valid(outs_valid),
        .ins_ready (oehb_ready)
    );

    assign ins_ready = oehb_ready;

    // Unsigned source, sign must never show up at the output
    a_sign_clear : assert property (@(posedge clk) disable iff (rst)
        outs_valid |-> !outs[31]);

endmodule

// File: verilog/conv_top.sv
`timescale 1ns/100ps

module conv_top import conv_pkg::*; #(
    parameter int DATA_TYPE = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [DATA_TYPE-1:0] ins,
    input  logic                 ins_valid,
    input  logic                 outs_ready,
    output logic                 ins_ready,
    output fp32_t                outs,
    output logic                 outs_valid
);

    // Link between input buffer and converter
    logic [DATA_TYPE-1:0] buf_data;
    logic                 buf_valid;
    logic                 conv_ready;

    // ------------------------------------------------------------------------
    // Input buffer, cuts the ready path coming back from the converter
    // ------------------------------------------------------------------------

    tehb #(
        .DATA_TYPE(DATA_TYPE)
    ) tehb_inst (
        .clk       (clk),
        .rst       (rst),
        .ins       (ins),
        .ins_valid (ins_valid),
        .outs_ready(conv_ready),
        .outs      (buf_data),
        .outs_valid(buf_valid),
        .ins_ready (ins_ready)
    );

    // ------------------------------------------------------------------------
    // Converter
    // ------------------------------------------------------------------------

    uitofp #(
        .DATA_TYPE(DATA_TYPE)
    ) uitofp_inst (
        .clk       (clk),
        .rst       (rst),
        .ins       (buf_data),
        .ins_valid (buf_valid),
        .outs_ready(outs_ready),
        .outs      (outs),
        .outs_valid(outs_valid),
        .ins_ready (conv_ready)
    );

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    // Free-running clock, first rising edge at half a period
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset spans RST_CYCLES rising edges, released just after the last one
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// File: sim/tb_conv_top.sv
`timescale 1ns/100ps

module tb_conv_top import conv_pkg::*;;

    localparam int CLK_PERIOD = 100;
    localparam int SEED       = 32'hfc1c_243a;
    // Token count over all tests for the watchdog budget
    localparam int NUM_TOKENS = 34 + 200 + 17 + 100;
    localparam int TIMEOUT_NS = (NUM_TOKENS * 4 + 200) * CLK_PERIOD;

    logic        clk;
    logic        rst;
    logic [31:0] ins;
    logic        ins_valid;
    logic        outs_ready = 1'b1;
    logic        ins_ready;
    fp32_t       outs;
    logic        outs_valid;

    // Expected value riding along with the token on ins
    fp32_t tok_exp;
    bit    tok_timed;
    bit    rand_ready;
    bit    stream_chk;
    string test_name;

    // Scoreboard queues in token order
    fp32_t exp_q[$];
    int    time_q[$];
    bit    timed_q[$];
    fp32_t exp_head;
    int    head_time;
    bit    head_timed;
    bit    exp_avail;
    int    cyc;

    int err_cnt;
    int err_mark;
    int pass_tests;
    int fail_tests;

    logic stall_in;

    tb_clock #(
        .PERIOD    (CLK_PERIOD),
        .RST_CYCLES(3)
    ) clock_inst (
        .clk(clk),
        .rst(rst)
    );

    conv_top #(
        .DATA_TYPE(32)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .ins       (ins),
        .ins_valid (ins_valid),
        .outs_ready(outs_ready),
        .ins_ready (ins_ready),
        .outs      (outs),
        .outs_valid(outs_valid)
    );

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    // Exponent from the leading one and the 23 bits below it
    function automatic fp32_t ref_conv(input logic [31:0] value);
        int          msb;
        logic [22:0] frac;
        msb = -1;
        for (int i = 31; i >= 0; i--) begin
            if (value[i] && (msb < 0)) begin
                msb = i;
            end
        end
        if (msb < 0) begin
            return '0;
        end
        if (msb >= 23) begin
            frac = 23'(value >> (msb - 23));
        end else begin
            frac = 23'(value << (23 - msb));
        end
        return {1'b0, 8'(msb + 127), frac};
    endfunction

    // ------------------------------------------------------------------------
    // Monitor pushes on input handshake and pops on output handshake
    // ------------------------------------------------------------------------

    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            time_q.delete();
            timed_q.delete();
            exp_avail <= 1'b0;
        end else begin
            if (outs_valid && outs_ready && (exp_q.size() != 0)) begin
                void'(exp_q.pop_front());
                void'(time_q.pop_front());
                void'(timed_q.pop_front());
            end
            if (ins_valid && ins_ready) begin
                exp_q.push_back(tok_exp);
                time_q.push_back(cyc);
                timed_q.push_back(tok_timed);
            end
            exp_avail <= (exp_q.size() != 0);
            if (exp_q.size() != 0) begin
                exp_head   <= exp_q[0];
                head_time  <= time_q[0];
                head_timed <= timed_q[0];
            end
        end
        cyc <= cyc + 1;
    end

    // Held token while the output side refuses
    assign stall_in = outs_valid && !outs_ready && ins_valid;

    // Random outs_ready only in the back-pressure test
    always @(posedge clk) begin
        #1;
        if (rand_ready) begin
            outs_ready = ($urandom % 4) != 0;
        end else begin
            outs_ready = 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    a_reset_state : assert property (@(posedge clk)
        rst |=> (!outs_valid && ins_ready))
    else begin
        $display("Outputs not idle around reset in test %s", test_name);
        err_cnt++;
    end

    a_no_extra : assert property (@(posedge clk) disable iff (rst)
        (outs_valid && outs_ready) |-> exp_avail)
    else begin
        $display("Output token with no input token pending in test %s", test_name);
        err_cnt++;
    end

    a_value : assert property (@(posedge clk) disable iff (rst)
        (outs_valid && outs_ready && exp_avail) |-> (outs == exp_head))
    else begin
        $display("FAILED %s expected %h actual %h", test_name,
            $sampled(exp_head), $sampled(outs));
        err_cnt++;
    end

    a_latency : assert property (@(posedge clk) disable iff (rst)
        (outs_valid && outs_ready && exp_avail && head_timed) |->
            ((cyc - head_time) == CONV_LATENCY))
    else begin
        $display("FAILED %s latency expected %0d actual %0d", test_name,
            CONV_LATENCY, $sampled(cyc) - $sampled(head_time));
        err_cnt++;
    end

    a_stall_hold : assert property (@(posedge clk) disable iff (rst)
        (outs_valid && !outs_ready) |=> (outs_valid && $stable(outs)))
    else begin
        $display("Output moved or dropped while stalled in test %s", test_name);
        err_cnt++;
    end

    a_ready_drop : assert property (@(posedge clk) disable iff (rst)
        (stall_in && $past(stall_in)) |-> !ins_ready)
    else begin
        $display("ins_ready still high after two stalled cycles in test %s", test_name);
        err_cnt++;
    end

    a_stream : assert property (@(posedge clk) disable iff (rst)
        (stream_chk && ins_valid) |-> ins_ready)
    else begin
        $display("Input refused while streaming into open pipe in test %s", test_name);
        err_cnt++;
    end

    // ------------------------------------------------------------------------
    // Stimulus helpers driving 1 ns after a rising edge
    // ------------------------------------------------------------------------

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Present one token and hold it until the handshake
    task automatic send_token(input logic [31:0] value, input fp32_t expected,
                              input bit timed);
        ins       = value;
        ins_valid = 1'b1;
        tok_exp   = expected;
        tok_timed = timed;
        do begin
            @(posedge clk);
        end while (!ins_ready);
        #1;
        ins_valid = 1'b0;
    endtask

    // Wait for every pending token to leave
    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        idle(2);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = err_cnt;
    endtask

    task automatic end_test();
        drain();
        if (err_cnt == err_mark) begin
            pass_tests++;
            $display("test %s passed", test_name);
        end else begin
            fail_tests++;
            $display("test %s failed with %0d errors", test_name, err_cnt - err_mark);
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    initial begin
        logic [31:0] value;
        void'($urandom(SEED));
        ins        = '0;
        ins_valid  = 1'b0;
        tok_exp    = '0;
        tok_timed  = 1'b0;
        rand_ready = 1'b0;
        stream_chk = 1'b0;
        err_cnt    = 0;
        pass_tests = 0;
        fail_tests = 0;
        cyc        = 0;

        // Reset values are checked on every edge around reset
        start_test("reset_state");
        while (rst !== 1'b0) begin
            @(posedge clk);
        end
        #1;
        idle(4);
        end_test();

        start_test("zero_and_exact");
        send_token(32'd0, 32'd0, 1'b0);
        for (int k = 0; k < 32; k++) begin
            send_token(32'd1 << k, {1'b0, 8'(k + 127), 23'd0}, 1'b0);
        end
        send_token(32'hffff_ffff, {1'b0, 8'd158, 23'h7f_ffff}, 1'b0);
        end_test();

        // Random shift spreads the leading one over all positions
        start_test("truncation_random");
        for (int n = 0; n < 200; n++) begin
            value = $urandom >> ($urandom % 32);
            send_token(value, ref_conv(value), 1'b0);
        end
        end_test();

        start_test("fixed_latency");
        value = $urandom;
        send_token(value, ref_conv(value), 1'b1);
        drain();
        stream_chk = 1'b1;
        for (int n = 0; n < 16; n++) begin
            value = $urandom >> ($urandom % 32);
            send_token(value, ref_conv(value), 1'b1);
        end
        stream_chk = 1'b0;
        end_test();

        start_test("back_pressure");
        rand_ready = 1'b1;
        for (int n = 0; n < 100; n++) begin
            idle($urandom % 3);
            value = $urandom >> ($urandom % 32);
            send_token(value, ref_conv(value), 1'b0);
        end
        rand_ready = 1'b0;
        end_test();

        $display("tests passed %0d failed %0d, check errors %0d",
            pass_tests, fail_tests, err_cnt);
        if ((fail_tests == 0) && (err_cnt == 0)) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog with four cycles per token plus slack
    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog timeout after %0d ns, test %s did not finish",
            TIMEOUT_NS, test_name);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: sim.f
verilog/conv_pkg.sv
verilog/delay_buffer.sv
verilog/oehb.sv
verilog/tehb.sv
verilog/uitofp.sv
verilog/conv_top.sv
sim/tb_clock.sv
sim/tb_conv_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the converter testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_LOG=build.log

rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_conv_top -f sim.f -o tb_conv_top > "$BUILD_LOG" 2>&1 \
    && ./obj_dir/tb_conv_top > "$LOG" 2>&1 \
    || { echo "Build or simulation error, see $BUILD_LOG and $LOG"; exit 1; }

grep -qx ">>> PASS" "$LOG" \
    && { echo "Simulation passed, log in $LOG"; exit 0; } \
    || { echo "Simulation failed, log in $LOG"; exit 1; }
